//--- design/mxfer_cfg_pkg.sv
/*
 * Channel geometry for the multi-symbol transfer channel: symbols per cycle,
 * symbol and count widths, and the size of the symbol buffer
 */
`default_nettype none

package mxfer_cfg_pkg;

    // most symbols that can be offered or taken in a single cycle
    localparam int NUM_SYMBOLS = 4;
    localparam int SYMBOL_WIDTH = 8;

    // a count runs from 0 to NUM_SYMBOLS inclusive, so it needs one extra code
    localparam int COUNT_WIDTH = 3;

    // buffer capacity in symbols, kept a power of two so pointers wrap for free
    localparam int FIFO_DEPTH = 16;
    localparam int PTR_WIDTH = 4;

    typedef logic [SYMBOL_WIDTH-1:0] symbol_t;
    typedef logic [COUNT_WIDTH-1:0] count_t;

    // index 0 holds the oldest symbol of the cycle
    typedef symbol_t [NUM_SYMBOLS-1:0] symbols_t;

endpackage

`default_nettype wire

//--- design/mxfer_monitor.sv
/*
 * Push-side protocol monitor. Watches sendable, receivable and data and keeps
 * a sticky flag for revocation, bad shifting and oversending
 */
`timescale 1ns/1ps
`default_nettype none

module mxfer_monitor (
    input  logic                       clk,
    input  logic                       arst_n,
    input  mxfer_cfg_pkg::count_t      push_sendable,
    input  mxfer_cfg_pkg::count_t      push_receivable,
    input  mxfer_cfg_pkg::symbols_t    push_data,
    output mxfer_status_pkg::status_t  proto_status
);

    // sendable limited to what the channel can carry in one cycle
    mxfer_cfg_pkg::count_t send_lim;
    mxfer_cfg_pkg::count_t xfer_count;
    mxfer_cfg_pkg::count_t owed_count;
    logic oversend;

    // symbols left behind this cycle, moved down to position 0
    mxfer_cfg_pkg::symbols_t owed_shifted;

    // present data with everything above the owed positions forced to zero
    mxfer_cfg_pkg::symbols_t data_masked;

    // what the sender owed at the end of the previous cycle
    mxfer_cfg_pkg::count_t owed_q;
    mxfer_cfg_pkg::symbols_t owed_data_q;

    mxfer_status_pkg::status_t status_set;
    mxfer_status_pkg::status_t status_q;

    assign oversend = (push_sendable > mxfer_cfg_pkg::NUM_SYMBOLS);
    assign send_lim = oversend ?
        mxfer_cfg_pkg::count_t'(mxfer_cfg_pkg::NUM_SYMBOLS) : push_sendable;

    // the transfer is the smaller of the two counts and the rest stays owed
    assign xfer_count = (send_lim < push_receivable) ? send_lim : push_receivable;
    assign owed_count = (send_lim > push_receivable) ? (send_lim - push_receivable) : '0;

    always_comb begin
        owed_shifted = '0;
        data_masked = '0;
        for (int i = 0; i < mxfer_cfg_pkg::NUM_SYMBOLS; i++) begin
            // owed + xfer never exceeds NUM_SYMBOLS, the range check only
            // keeps the index inside the array for every possible count
            if ((i < owed_count) && (i + xfer_count < mxfer_cfg_pkg::NUM_SYMBOLS)) begin
                owed_shifted[i] = push_data[i + xfer_count];
            end
            if (i < owed_q) begin
                data_masked[i] = push_data[i];
            end
        end
    end

    // owed count is control state, cleared so the first cycle checks nothing
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            owed_q <= '0;
        end else begin
            owed_q <= owed_count;
        end
    end

    // the owed symbols are only compared while owed_q is nonzero
    always_ff @(posedge clk) begin
        owed_data_q <= owed_shifted;
    end

    always_comb begin
        status_set = '0;
        // revocation and shift errors are judged one cycle after the owing one
        status_set[mxfer_status_pkg::ERR_REVOKE] = (push_sendable < owed_q);
        status_set[mxfer_status_pkg::ERR_SHIFT] =
            (owed_q != '0) && (data_masked != owed_data_q);
        // oversend is a property of the current cycle alone
        status_set[mxfer_status_pkg::ERR_OVERSEND] = oversend;
    end

    // flags only ever get set, reset is the one way to clear them
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            status_q <= '0;
        end else begin
            status_q <= status_q | status_set;
        end
    end

    assign proto_status = status_q;

endmodule

`default_nettype wire

//--- design/mxfer_status_pkg.sv
/*
 * Protocol status word of the transfer channel: one sticky bit per kind of
 * sender violation seen on the push side
 */
`default_nettype none

package mxfer_status_pkg;

    // sendable dropped below the symbols still owed from the last cycle
    localparam int ERR_REVOKE = 0;

    // owed symbols did not come back shifted down to position 0 unchanged
    localparam int ERR_SHIFT = 1;

    // sendable above NUM_SYMBOLS, which the channel cannot carry
    localparam int ERR_OVERSEND = 2;

    localparam int ERR_COUNT = 3;

    typedef logic [ERR_COUNT-1:0] status_t;

endpackage

`default_nettype wire

//--- design/mxfer_symbol_fifo.sv
/*
 * Circular symbol buffer. Takes up to NUM_SYMBOLS symbols per cycle on the push
 * side and offers up to NUM_SYMBOLS on the pop side, both with sendable/receivable
 */
`timescale 1ns/1ps
`default_nettype none

module mxfer_symbol_fifo (
    input  logic                     clk,
    input  logic                     arst_n,
    input  mxfer_cfg_pkg::count_t    push_sendable,
    input  mxfer_cfg_pkg::symbols_t  push_data,
    output mxfer_cfg_pkg::count_t    push_receivable,
    output mxfer_cfg_pkg::count_t    pop_sendable,
    input  mxfer_cfg_pkg::count_t    pop_receivable,
    output mxfer_cfg_pkg::symbols_t  pop_data
);

    // symbol storage, payload only
    mxfer_cfg_pkg::symbol_t mem [mxfer_cfg_pkg::FIFO_DEPTH];

    logic [mxfer_cfg_pkg::PTR_WIDTH-1:0] rd_ptr;
    logic [mxfer_cfg_pkg::PTR_WIDTH-1:0] wr_ptr;

    // occupancy needs one bit more than a pointer to hold a full buffer
    logic [mxfer_cfg_pkg::PTR_WIDTH:0] occupancy;
    logic [mxfer_cfg_pkg::PTR_WIDTH:0] free_space;

    // per-position memory indices, wrapping at the end of the buffer
    logic [mxfer_cfg_pkg::PTR_WIDTH-1:0] rd_idx [mxfer_cfg_pkg::NUM_SYMBOLS];
    logic [mxfer_cfg_pkg::PTR_WIDTH-1:0] wr_idx [mxfer_cfg_pkg::NUM_SYMBOLS];

    mxfer_cfg_pkg::count_t send_lim;
    mxfer_cfg_pkg::count_t push_count;
    mxfer_cfg_pkg::count_t pop_count;

    // free space is taken before any pop of this cycle, so push_receivable
    // depends on registered state only and never on pop_receivable
    assign free_space = (mxfer_cfg_pkg::PTR_WIDTH + 1)'(mxfer_cfg_pkg::FIFO_DEPTH) - occupancy;

    assign push_receivable = (free_space > mxfer_cfg_pkg::NUM_SYMBOLS) ?
        mxfer_cfg_pkg::count_t'(mxfer_cfg_pkg::NUM_SYMBOLS) :
        mxfer_cfg_pkg::count_t'(free_space);

    // an oversending sender still moves at most NUM_SYMBOLS symbols
    assign send_lim = (push_sendable > mxfer_cfg_pkg::NUM_SYMBOLS) ?
        mxfer_cfg_pkg::count_t'(mxfer_cfg_pkg::NUM_SYMBOLS) : push_sendable;

    assign push_count = (send_lim < push_receivable) ? send_lim : push_receivable;

    // the pop side offers whatever is stored, up to one cycle's worth
    assign pop_sendable = (occupancy > mxfer_cfg_pkg::NUM_SYMBOLS) ?
        mxfer_cfg_pkg::count_t'(mxfer_cfg_pkg::NUM_SYMBOLS) :
        mxfer_cfg_pkg::count_t'(occupancy);

    // pop_receivable may be any count, the min keeps the pop within what is offered
    assign pop_count = (pop_sendable < pop_receivable) ? pop_sendable : pop_receivable;

    for (genvar i = 0; i < mxfer_cfg_pkg::NUM_SYMBOLS; i++) begin : gen_idx
        assign rd_idx[i] = rd_ptr + mxfer_cfg_pkg::PTR_WIDTH'(i);
        assign wr_idx[i] = wr_ptr + mxfer_cfg_pkg::PTR_WIDTH'(i);

        // unused positions read as zero, so symbols still owed next cycle
        // simply reappear at position 0 once the read pointer has moved
        assign pop_data[i] = (i < pop_sendable) ? mem[rd_idx[i]] : '0;
    end

    // accepted symbols land at consecutive entries starting at the write pointer
    always_ff @(posedge clk) begin
        for (int i = 0; i < mxfer_cfg_pkg::NUM_SYMBOLS; i++) begin
            if (i < push_count) begin
                mem[wr_idx[i]] <= push_data[i];
            end
        end
    end

    // pointers wrap by truncation since the depth is a power of two
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            occupancy <= '0;
        end else begin
            wr_ptr <= wr_ptr + push_count;
            rd_ptr <= rd_ptr + pop_count;
            // push and pop in the same cycle both count
            occupancy <= occupancy + push_count - pop_count;
        end
    end

endmodule

`default_nettype wire

//--- design/mxfer_top.sv
/*
 * Multi-symbol transfer channel. The symbol FIFO carries the data and the
 * monitor reports protocol violations of the upstream sender
 */
`timescale 1ns/1ps
`default_nettype none

module mxfer_top (
    input  logic                       clk,
    input  logic                       arst_n,
    input  mxfer_cfg_pkg::count_t      push_sendable,
    input  mxfer_cfg_pkg::symbols_t    push_data,
    output mxfer_cfg_pkg::count_t      push_receivable,
    output mxfer_cfg_pkg::count_t      pop_sendable,
    input  mxfer_cfg_pkg::count_t      pop_receivable,
    output mxfer_cfg_pkg::symbols_t    pop_data,
    output mxfer_status_pkg::status_t  proto_status
);

    // the FIFO owns the push and pop sides of the channel
    mxfer_symbol_fifo u_fifo (
        .clk             (clk),
        .arst_n          (arst_n),
        .push_sendable   (push_sendable),
        .push_data       (push_data),
        .push_receivable (push_receivable),
        .pop_sendable    (pop_sendable),
        .pop_receivable  (pop_receivable),
        .pop_data        (pop_data)
    );

    // the monitor only listens, including to the FIFO's own receivable
    mxfer_monitor u_monitor (
        .clk             (clk),
        .arst_n          (arst_n),
        .push_sendable   (push_sendable),
        .push_receivable (push_receivable),
        .push_data       (push_data),
        .proto_status    (proto_status)
    );

endmodule

`default_nettype wire

//--- mxfer_top.f
+incdir+include
design/mxfer_cfg_pkg.sv
design/mxfer_status_pkg.sv
design/mxfer_monitor.sv
design/mxfer_symbol_fifo.sv
design/mxfer_top.sv
tests/tb_mxfer_top.sv

//--- include/mxfer_tb_model.svh
/*
 * Reference model functions for the transfer channel testbench: transfer
 * count, push-side receivable and the expected status word
 */
`ifndef MXFER_TB_MODEL_SVH
`define MXFER_TB_MODEL_SVH

// symbols that move in one cycle, oversend limited like the FIFO does
function automatic mxfer_cfg_pkg::count_t exp_xfer(
    input mxfer_cfg_pkg::count_t sendable,
    input mxfer_cfg_pkg::count_t receivable
);
    mxfer_cfg_pkg::count_t lim;
    lim = (sendable > mxfer_cfg_pkg::NUM_SYMBOLS) ?
        mxfer_cfg_pkg::count_t'(mxfer_cfg_pkg::NUM_SYMBOLS) : sendable;
    return (lim < receivable) ? lim : receivable;
endfunction

// push_receivable follows the free space of the model buffer
function automatic mxfer_cfg_pkg::count_t exp_receivable(input int occupancy);
    int free_space;
    free_space = mxfer_cfg_pkg::FIFO_DEPTH - occupancy;
    if (free_space > mxfer_cfg_pkg::NUM_SYMBOLS) begin
        return mxfer_cfg_pkg::count_t'(mxfer_cfg_pkg::NUM_SYMBOLS);
    end
    return mxfer_cfg_pkg::count_t'(free_space);
endfunction

// status after one edge, from the owed state left by the previous cycle
function automatic mxfer_status_pkg::status_t exp_status(
    input mxfer_status_pkg::status_t prev,
    input mxfer_cfg_pkg::count_t owed_prev,
    input mxfer_cfg_pkg::count_t sendable,
    input bit owed_data_ok
);
    mxfer_status_pkg::status_t next;
    next = prev;
    if (sendable < owed_prev) next[mxfer_status_pkg::ERR_REVOKE] = 1'b1;
    if ((owed_prev != 0) && !owed_data_ok) next[mxfer_status_pkg::ERR_SHIFT] = 1'b1;
    if (sendable > mxfer_cfg_pkg::NUM_SYMBOLS) next[mxfer_status_pkg::ERR_OVERSEND] = 1'b1;
    return next;
endfunction

`endif

//--- tests/tb_mxfer_top.sv
/*
 * Testbench for the transfer channel. Drives legal and illegal senders, keeps a
 * scoreboard of accepted symbols and checks counts, popped data and status flags
 */
`timescale 1ns/1ps
`default_nettype none

module tb_mxfer_top;

    `include "mxfer_tb_model.svh"

    logic clk;
    logic arst_n;
    mxfer_cfg_pkg::count_t push_sendable;
    mxfer_cfg_pkg::symbols_t push_data;
    mxfer_cfg_pkg::count_t push_receivable;
    mxfer_cfg_pkg::count_t pop_sendable;
    mxfer_cfg_pkg::count_t pop_receivable;
    mxfer_cfg_pkg::symbols_t pop_data;
    mxfer_status_pkg::status_t proto_status;

    // model state that the comparing process advances once per rising edge
    int model_occ;
    mxfer_cfg_pkg::symbol_t sb[$];
    mxfer_status_pkg::status_t exp_stat;
    mxfer_cfg_pkg::count_t owed_prev;
    mxfer_cfg_pkg::symbols_t owed_syms;
    int last_push_count;

    // the sender keeps the symbols not yet taken and the count it offered last cycle
    mxfer_cfg_pkg::symbol_t pend[$];
    int sent_count;

    int err_values;
    int err_timeouts;

    mxfer_top u_dut (
        .clk             (clk),
        .arst_n          (arst_n),
        .push_sendable   (push_sendable),
        .push_data       (push_data),
        .push_receivable (push_receivable),
        .pop_sendable    (pop_sendable),
        .pop_receivable  (pop_receivable),
        .pop_data        (pop_data),
        .proto_status    (proto_status)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic check_count(input string name, input mxfer_cfg_pkg::count_t got,
                               input mxfer_cfg_pkg::count_t exp);
        if (got !== exp) begin
            $display("ERROR %s: got 0x%0h, expected 0x%0h", name, got, exp);
            err_values++;
        end
    endtask

    task automatic check_symbol(input string name, input mxfer_cfg_pkg::symbol_t got,
                                input mxfer_cfg_pkg::symbol_t exp);
        if (got !== exp) begin
            $display("ERROR %s: got 0x%0h, expected 0x%0h", name, got, exp);
            err_values++;
        end
    endtask

    task automatic check_status(input string name, input mxfer_status_pkg::status_t got,
                                input mxfer_status_pkg::status_t exp);
        if (got !== exp) begin
            $display("ERROR %s: got 0x%0h, expected 0x%0h", name, got, exp);
            err_values++;
        end
    endtask

    // sampled at the rising edge, inputs having settled since the falling edge
    always @(posedge clk) begin : compare_edge
        mxfer_cfg_pkg::count_t exp_recv;
        mxfer_cfg_pkg::count_t exp_pop_send;
        mxfer_cfg_pkg::count_t pop_n;
        mxfer_cfg_pkg::count_t push_n;
        mxfer_cfg_pkg::count_t lim;
        bit data_ok;
        if (!arst_n) begin
            model_occ = 0;
            sb.delete();
            exp_stat = '0;
            owed_prev = '0;
            owed_syms = '0;
            last_push_count = 0;
        end else begin
            exp_recv = exp_receivable(model_occ);
            exp_pop_send = (model_occ > mxfer_cfg_pkg::NUM_SYMBOLS) ?
                mxfer_cfg_pkg::count_t'(mxfer_cfg_pkg::NUM_SYMBOLS) :
                mxfer_cfg_pkg::count_t'(model_occ);
            check_count("push_receivable", push_receivable, exp_recv);
            check_count("pop_sendable", pop_sendable, exp_pop_send);
            check_status("proto_status", proto_status, exp_stat);
            // every popped position must match the scoreboard head, in order
            pop_n = exp_xfer(exp_pop_send, pop_receivable);
            for (int i = 0; i < pop_n; i++) begin
                if (sb.size() == 0) begin
                    $display("DUT popped a symbol while the scoreboard was empty");
                    err_values++;
                end else begin
                    check_symbol("pop_data", pop_data[i], sb.pop_front());
                end
            end
            push_n = exp_xfer(push_sendable, exp_recv);
            for (int i = 0; i < push_n; i++) begin
                sb.push_back(push_data[i]);
            end
            // owed symbols from last cycle must sit at position 0 onward
            data_ok = 1'b1;
            for (int i = 0; i < owed_prev; i++) begin
                if (push_data[i] !== owed_syms[i]) data_ok = 1'b0;
            end
            exp_stat = exp_status(exp_stat, owed_prev, push_sendable, data_ok);
            lim = (push_sendable > mxfer_cfg_pkg::NUM_SYMBOLS) ?
                mxfer_cfg_pkg::count_t'(mxfer_cfg_pkg::NUM_SYMBOLS) : push_sendable;
            owed_prev = (lim > exp_recv) ? (lim - exp_recv) : '0;
            owed_syms = '0;
            for (int i = 0; i < owed_prev; i++) begin
                owed_syms[i] = push_data[i + push_n];
            end
            model_occ = model_occ + int'(push_n) - int'(pop_n);
            last_push_count = int'(push_n);
        end
    end

    function automatic mxfer_cfg_pkg::symbols_t rand_symbols();
        mxfer_cfg_pkg::symbols_t d;
        for (int i = 0; i < mxfer_cfg_pkg::NUM_SYMBOLS; i++) begin
            d[i] = mxfer_cfg_pkg::symbol_t'($urandom);
        end
        return d;
    endfunction

    task automatic offer(input int n, input mxfer_cfg_pkg::symbols_t d);
        push_sendable = mxfer_cfg_pkg::count_t'(n);
        push_data = d;
        sent_count = n;
    endtask

    // the legal sender drops what was taken and re-offers the rest, maybe with new symbols
    task automatic sender_step(input bit allow_new);
        int owed;
        int n;
        for (int i = 0; i < last_push_count; i++) begin
            void'(pend.pop_front());
        end
        owed = sent_count - last_push_count;
        while (pend.size() < mxfer_cfg_pkg::NUM_SYMBOLS) begin
            pend.push_back(mxfer_cfg_pkg::symbol_t'($urandom));
        end
        n = allow_new ? owed + int'($urandom_range(mxfer_cfg_pkg::NUM_SYMBOLS - owed, 0)) : owed;
        push_data = '0;
        for (int i = 0; i < n; i++) begin
            push_data[i] = pend[i];
        end
        push_sendable = mxfer_cfg_pkg::count_t'(n);
        sent_count = n;
    endtask

    task automatic apply_reset();
        arst_n = 1'b0;
        offer(0, '0);
        pop_receivable = '0;
        pend.delete();
        repeat (4) @(negedge clk);
        arst_n = 1'b1;
    endtask

    // pushes with the pop side closed until the model holds target symbols
    task automatic fill_to(input int target);
        int n;
        for (int k = 0; k < 40 && model_occ != target; k++) begin
            n = target - model_occ;
            if (n > mxfer_cfg_pkg::NUM_SYMBOLS) n = mxfer_cfg_pkg::NUM_SYMBOLS;
            offer(n, rand_symbols());
            @(negedge clk);
        end
        offer(0, '0);
        if (model_occ != target) begin
            $display("timed out filling the FIFO to %0d symbols", target);
            err_timeouts++;
        end
    endtask

    task automatic drain_fifo();
        offer(0, '0);
        pop_receivable = mxfer_cfg_pkg::count_t'(mxfer_cfg_pkg::NUM_SYMBOLS);
        for (int k = 0; k < 40 && model_occ != 0; k++) begin
            @(negedge clk);
        end
        if (model_occ != 0) begin
            $display("timed out draining the FIFO, %0d symbols left", model_occ);
            err_timeouts++;
        end
    endtask

    task automatic wait_status_bit(input int idx, input string name);
        for (int k = 0; k < 10 && !proto_status[idx]; k++) begin
            @(negedge clk);
        end
        if (!proto_status[idx]) begin
            $display("timed out waiting for the %s flag", name);
            err_timeouts++;
        end
        repeat (3) @(negedge clk);
        if (!proto_status[idx]) begin
            $display("the %s flag cleared without a reset", name);
            err_values++;
        end
    endtask

    initial begin : main
        mxfer_cfg_pkg::symbols_t d;
        mxfer_cfg_pkg::symbols_t d2;
        bit done;
        err_values = 0;
        err_timeouts = 0;
        sent_count = 0;
        arst_n = 1'b0;
        push_sendable = '0;
        push_data = '0;
        pop_receivable = '0;
        void'($urandom(32'he441));
        @(negedge clk);
        apply_reset();
        check_count("push_receivable", push_receivable, mxfer_cfg_pkg::NUM_SYMBOLS);
        check_count("pop_sendable", pop_sendable, '0);
        check_status("proto_status", proto_status, '0);

        // legal random traffic against a random pop side
        for (int k = 0; k < 300; k++) begin
            sender_step(1'b1);
            pop_receivable = mxfer_cfg_pkg::count_t'($urandom_range(mxfer_cfg_pkg::NUM_SYMBOLS, 0));
            @(negedge clk);
        end
        done = 1'b0;
        for (int k = 0; k < 100 && !done; k++) begin
            sender_step(1'b0);
            pop_receivable = mxfer_cfg_pkg::count_t'(mxfer_cfg_pkg::NUM_SYMBOLS);
            done = (sent_count == 0) && (model_occ == 0);
            if (!done) @(negedge clk);
        end
        if (!done) begin
            $display("timed out finishing the random traffic");
            err_timeouts++;
        end
        // a legal sender never raises a flag
        check_status("proto_status", proto_status, '0);

        // back-pressure up to a full buffer, then everything drains in order
        pop_receivable = '0;
        fill_to(mxfer_cfg_pkg::FIFO_DEPTH);
        check_count("push_receivable", push_receivable, '0);
        drain_fifo();

        // revocation with 4 offered against 2, followed by only 1 of the 2 owed symbols
        apply_reset();
        fill_to(mxfer_cfg_pkg::FIFO_DEPTH - 2);
        check_count("push_receivable", push_receivable, 2);
        d = rand_symbols();
        offer(4, d);
        @(negedge clk);
        d2 = '0;
        d2[0] = d[2];
        d2[1] = d[3];
        offer(1, d2);
        pop_receivable = mxfer_cfg_pkg::count_t'(mxfer_cfg_pkg::NUM_SYMBOLS);
        @(negedge clk);
        // the remaining owed symbol is taken once the pop has made room
        @(negedge clk);
        offer(0, '0);
        wait_status_bit(mxfer_status_pkg::ERR_REVOKE, "revoke");
        apply_reset();

        // shift violation with 4 offered against 1 and the middle owed symbol altered next
        fill_to(mxfer_cfg_pkg::FIFO_DEPTH - 1);
        d = rand_symbols();
        offer(4, d);
        @(negedge clk);
        d2 = '0;
        d2[0] = d[1];
        d2[1] = ~d[2];
        d2[2] = d[3];
        offer(3, d2);
        pop_receivable = mxfer_cfg_pkg::count_t'(mxfer_cfg_pkg::NUM_SYMBOLS);
        @(negedge clk);
        @(negedge clk);
        offer(0, '0);
        wait_status_bit(mxfer_status_pkg::ERR_SHIFT, "shift");
        drain_fifo();
        apply_reset();

        // oversends of 5, 6 and 7 each store NUM_SYMBOLS symbols in a FIFO that is not popped
        pop_receivable = '0;
        for (int n = 5; n <= 7; n++) begin
            offer(n, rand_symbols());
            @(negedge clk);
        end
        offer(0, '0);
        check_count("push_receivable", push_receivable,
                    exp_receivable(3 * mxfer_cfg_pkg::NUM_SYMBOLS));
        wait_status_bit(mxfer_status_pkg::ERR_OVERSEND, "oversend");
        drain_fifo();

        $display("errors: %0d mismatches, %0d timeouts", err_values, err_timeouts);
        if (err_values == 0 && err_timeouts == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
